// File: Makefile
TOP := tb_i3c_target

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f $(wildcard *.sv)
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: i3c_addr_match.sv
/*
  Header register and address decode.
  Dynamic address wins over static; with neither valid nothing matches.
  The broadcast byte is flagged independently of the own address.
*/
`timescale 1ns/100ps

module i3c_addr_match (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  hdr_load_i,
  input  i3c_bus_pkg::hdr_byte_u hdr_byte_i,
  input  logic                  clear_i,
  input  logic                  start_i,
  input  i3c_bus_pkg::addr_t    sta_addr_i,
  input  logic                  sta_addr_valid_i,
  input  i3c_bus_pkg::addr_t    dyn_addr_i,
  input  logic                  dyn_addr_valid_i,
  output logic                  addr_match_o,
  output logic                  rsvd_match_o,
  output logic                  rnw_o,
  output i3c_bus_pkg::byte_t    last_addr_o,
  output logic                  last_addr_valid_o
);
  import i3c_bus_pkg::*;

  hdr_byte_u hdr_q;

  // Header byte, dropped again once the FSM is back in Idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_q <= '0;
    end else if (hdr_load_i) begin
      hdr_q <= hdr_byte_i;
    end else if (clear_i) begin
      hdr_q <= '0;
    end
  end

  // Address precedence
  always_comb begin
    if (dyn_addr_valid_i) begin
      addr_match_o = (hdr_q.fields.addr == dyn_addr_i);
    end else if (sta_addr_valid_i) begin
      addr_match_o = (hdr_q.fields.addr == sta_addr_i);
    end else begin
      addr_match_o = 1'b0;
    end
  end

  assign rsvd_match_o = (hdr_q.raw == RsvdByte);
  assign rnw_o        = hdr_q.fields.rnw;
  assign last_addr_o  = hdr_q.raw;

  // A start invalidates the report until the next header arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_addr_valid_o <= 1'b0;
    end else if (start_i) begin
      last_addr_valid_o <= 1'b0;
    end else if (hdr_load_i) begin
      last_addr_valid_o <= 1'b1;
    end
  end

endmodule : i3c_addr_match

// File: i3c_bus_pkg.sv
/*
  Bus-level types and constants for the SDR target.
  Only 7-bit addressing; a header byte is {address, RnW}.
*/
package i3c_bus_pkg;

  // One SDR byte on the bus
  typedef logic [7:0] byte_t;

  // 7-bit target address
  typedef logic [6:0] addr_t;

  // Header view of a byte, address in the upper bits
  typedef struct packed {
    addr_t addr;
    logic  rnw;
  } hdr_fields_t;

  // The byte after a start is an address+RnW,
  // the byte after a broadcast is a command code
  typedef union packed {
    hdr_fields_t fields;
    byte_t       raw;
  } hdr_byte_u;

  // Broadcast address 7'h7E with RnW low
  localparam byte_t RsvdByte = 8'hFC;

  // SDA level the target drives to acknowledge
  localparam logic AckValue = 1'b0;

endpackage : i3c_bus_pkg

// File: i3c_fsm_pkg.sv
/*
  State encoding of the target controller.
  The datapaths read the state only through FSM strobes.
*/
package i3c_fsm_pkg;

  typedef enum logic [3:0] {
    // Waiting for a start
    Idle,
    // First byte after S/Sr and its decision and ACK
    RxFByte,
    CheckFByte,
    TxAckFByte,
    // Byte after a broadcast, CCC code or Sr
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    // Private write loop
    RxPWriteData,
    RxPWriteTbit,
    // Private read loop
    TxPReadData,
    TxPReadTbit,
    // Not for us, wait for Sr or P
    Wait,
    // CCC handed to the external engine
    DoCCC,
    DoneCCC
  } state_e;

endpackage : i3c_fsm_pkg

// File: i3c_rx_path.sv
/*
  Private write datapath with odd parity over byte and T-bit.
  A full RX FIFO never stalls the bus: a byte arriving while the
  previous one is still pending is dropped and flagged.
*/
`timescale 1ns/100ps

module i3c_rx_path (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               byte_done_i,
  input  logic               tbit_done_i,
  input  i3c_bus_pkg::byte_t rx_data_i,
  input  logic               rx_fifo_wready_i,
  output logic               parity_err_o,
  output logic               rx_overflow_err_o,
  output logic               rx_fifo_wvalid_o,
  output i3c_bus_pkg::byte_t rx_fifo_wdata_o
);
  import i3c_bus_pkg::*;

  byte_t data_q;
  byte_t wdata_q;
  logic  parity_exp;
  logic  push;
  logic  pending;
  logic  wvalid_q;
  logic  overflow_q;

  // Byte as received, waiting for its T-bit
  always_ff @(posedge clk_i) begin
    if (byte_done_i) begin
      data_q <= rx_data_i;
    end
  end

  // T-bit makes the count of ones odd
  assign parity_exp   = ^{data_q, 1'b1};
  assign parity_err_o = tbit_done_i & (rx_data_i[0] != parity_exp);

  // Good byte completed
  assign push    = tbit_done_i & ~parity_err_o;
  // Previous byte not taken in this cycle
  assign pending = wvalid_q & ~rx_fifo_wready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wvalid_q   <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      overflow_q <= push & pending;
      if (push && !pending) begin
        wvalid_q <= 1'b1;
      end else if (rx_fifo_wready_i) begin
        wvalid_q <= 1'b0;
      end
    end
  end

  // FIFO word, stable while valid is high
  always_ff @(posedge clk_i) begin
    if (push && !pending) begin
      wdata_q <= data_q;
    end
  end

  assign rx_fifo_wvalid_o  = wvalid_q;
  assign rx_fifo_wdata_o   = wdata_q;
  assign rx_overflow_err_o = overflow_q;

endmodule : i3c_rx_path

// File: i3c_target_fsm.sv
/*
  SDR target controller; the only owner of the PHY requests.
  A stop forces Idle from any state. Reads after a broadcast and Sr
  are ACKed only with a TX descriptor available.
*/
`timescale 1ns/100ps

module i3c_target_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   target_enable_i,
  input  logic                   bus_start_det_i,
  input  logic                   bus_rstart_det_i,
  input  logic                   bus_stop_det_i,
  input  logic                   bus_rx_done_i,
  input  i3c_bus_pkg::hdr_byte_u bus_rx_data_i,
  input  logic                   bus_tx_done_i,
  input  logic                   addr_match_i,
  input  logic                   rsvd_match_i,
  input  logic                   rnw_i,
  input  logic                   tx_desc_avail_i,
  input  logic                   tx_fifo_rvalid_i,
  input  logic                   tx_last_byte_i,
  input  logic                   tx_end_i,
  input  i3c_bus_pkg::byte_t     tx_byte_i,
  input  logic                   is_ccc_done_i,
  input  logic                   is_next_ccc_i,
  output logic                   bus_rx_req_byte_o,
  output logic                   bus_rx_req_bit_o,
  output logic                   bus_tx_req_byte_o,
  output logic                   bus_tx_req_bit_o,
  output i3c_bus_pkg::byte_t     bus_tx_req_value_o,
  output logic                   hdr_load_o,
  output logic                   rx_byte_done_o,
  output logic                   rx_tbit_done_o,
  output logic                   tx_load_o,
  output logic                   tx_tbit_done_o,
  output logic                   tx_fifo_rready_o,
  output logic                   ccc_valid_o,
  output i3c_bus_pkg::byte_t     ccc_o,
  output logic                   target_idle_o,
  output logic                   target_transmitting_o,
  output logic                   xfer_in_progress_o,
  output logic                   event_target_nack_o
);
  import i3c_bus_pkg::*;
  import i3c_fsm_pkg::*;

  state_e state_q;
  state_e state_d;
  logic   start_det;
  logic   tx_data_ready;
  byte_t  ccc_q;
  logic   xfer_q;

  // Sr is handled like S except right after a broadcast
  assign start_det = bus_start_det_i | bus_rstart_det_i;

  // FIFO shows a byte, or presents the final one
  assign tx_data_ready = tx_fifo_rvalid_i | tx_last_byte_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (target_enable_i && start_det) state_d = RxFByte;
      end
      RxFByte: begin
        if (bus_rx_done_i) state_d = CheckFByte;
      end
      CheckFByte: begin
        state_d = (rsvd_match_i || addr_match_i) ? TxAckFByte : Wait;
      end
      TxAckFByte: begin
        if (bus_tx_done_i) begin
          if (rsvd_match_i) state_d = RxSByte;
          else if (!rnw_i) state_d = RxPWriteData;
          else state_d = tx_data_ready ? TxPReadData : Wait;
        end
      end
      RxSByte: begin
        // Sr here means a direct address follows
        if (start_det) state_d = RxSByteRepeated;
        else if (bus_rx_done_i) state_d = DoCCC;
      end
      RxSByteRepeated: begin
        if (bus_rx_done_i) state_d = CheckSByte;
      end
      CheckSByte: begin
        if (addr_match_i && (tx_desc_avail_i || !rnw_i)) state_d = TxAckSByte;
        else state_d = Wait;
      end
      TxAckSByte: begin
        if (bus_tx_done_i) begin
          if (!rnw_i) state_d = RxPWriteData;
          else state_d = tx_data_ready ? TxPReadData : Wait;
        end
      end
      RxPWriteData: begin
        if (start_det) state_d = RxFByte;
        else if (bus_rx_done_i) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (start_det) state_d = RxFByte;
        else if (bus_rx_done_i) state_d = RxPWriteData;
      end
      TxPReadData: begin
        if (start_det) state_d = RxFByte;
        else if (bus_tx_done_i) state_d = TxPReadTbit;
      end
      TxPReadTbit: begin
        // Last byte or an empty FIFO ends the read
        if (start_det) state_d = RxFByte;
        else if (bus_tx_done_i) state_d = (!tx_end_i && tx_data_ready) ? TxPReadData : Wait;
      end
      Wait: begin
        if (start_det) state_d = RxFByte;
      end
      DoCCC: begin
        if (is_ccc_done_i) state_d = DoneCCC;
        else if (is_next_ccc_i) state_d = RxSByte;
      end
      DoneCCC: begin
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
    // Stop overrides everything
    if (bus_stop_det_i) state_d = Idle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // PHY requests, receive side dropped by S/Sr
  always_comb begin
    bus_rx_req_byte_o  = 1'b0;
    bus_rx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_value_o = '0;
    case (state_q)
      RxFByte, RxSByte, RxSByteRepeated, RxPWriteData: begin
        bus_rx_req_byte_o = ~start_det;
      end
      RxPWriteTbit: begin
        bus_rx_req_bit_o = ~start_det;
      end
      TxAckFByte, TxAckSByte: begin
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, AckValue};
      end
      TxPReadData: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = tx_byte_i;
      end
      TxPReadTbit: begin
        // T-bit low marks the end of data
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~tx_end_i};
      end
      default: begin
        bus_tx_req_value_o = '0;
      end
    endcase
  end

  // Strobes for the matcher and datapaths
  assign hdr_load_o     = bus_rx_done_i & (state_q inside {RxFByte, RxSByteRepeated});
  assign rx_byte_done_o = bus_rx_done_i & (state_q == RxPWriteData);
  assign rx_tbit_done_o = bus_rx_done_i & (state_q == RxPWriteTbit);
  assign tx_tbit_done_o = bus_tx_done_i & (state_q == TxPReadTbit);

  // Pop on entry, the byte is captured on the same edge
  assign tx_fifo_rready_o = (state_d == TxPReadData) & (state_q != TxPReadData);
  assign tx_load_o        = tx_fifo_rready_o;

  // Command code is the byte following the broadcast
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ccc_q <= '0;
    end else if (bus_rx_done_i && state_q == RxSByte && !start_det) begin
      ccc_q <= bus_rx_data_i.raw;
    end
  end

  assign ccc_o       = ccc_q;
  assign ccc_valid_o = (state_q == DoCCC);

  // Set once a header addresses this target
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_q <= 1'b0;
    end else if (state_q == Idle) begin
      xfer_q <= 1'b0;
    end else if (state_q inside {CheckFByte, CheckSByte}) begin
      xfer_q <= addr_match_i;
    end
  end

  assign xfer_in_progress_o    = xfer_q;
  assign target_idle_o         = (state_q == Idle);
  assign target_transmitting_o = state_q inside {TxAckFByte, TxAckSByte, TxPReadData, TxPReadTbit};
  assign event_target_nack_o   = (state_d == Wait) & (state_q != Wait);

endmodule : i3c_target_fsm

// File: i3c_target_top.sv
/*
  SDR target top: FSM, address matcher and the two datapaths.
  Expects a bit/byte PHY with one-cycle done pulses.
*/
`timescale 1ns/100ps

module i3c_target_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               target_enable_i,
  // Bus events and PHY
  input  logic               bus_start_det_i,
  input  logic               bus_rstart_det_i,
  input  logic               bus_stop_det_i,
  input  logic               bus_rx_done_i,
  input  i3c_bus_pkg::byte_t bus_rx_data_i,
  input  logic               bus_tx_done_i,
  output logic               bus_rx_req_byte_o,
  output logic               bus_rx_req_bit_o,
  output logic               bus_tx_req_byte_o,
  output logic               bus_tx_req_bit_o,
  output i3c_bus_pkg::byte_t bus_tx_req_value_o,
  // Own addresses
  input  i3c_bus_pkg::addr_t sta_addr_i,
  input  logic               sta_addr_valid_i,
  input  i3c_bus_pkg::addr_t dyn_addr_i,
  input  logic               dyn_addr_valid_i,
  output i3c_bus_pkg::byte_t last_addr_o,
  output logic               last_addr_valid_o,
  // RX FIFO
  output logic               rx_fifo_wvalid_o,
  output i3c_bus_pkg::byte_t rx_fifo_wdata_o,
  input  logic               rx_fifo_wready_i,
  output logic               parity_err_o,
  output logic               rx_overflow_err_o,
  // TX FIFO
  input  logic               tx_desc_avail_i,
  input  logic               tx_fifo_rvalid_i,
  input  i3c_bus_pkg::byte_t tx_fifo_rdata_i,
  input  logic               tx_last_byte_i,
  output logic               tx_fifo_rready_o,
  // CCC engine
  output i3c_bus_pkg::byte_t ccc_o,
  output logic               ccc_valid_o,
  input  logic               is_ccc_done_i,
  input  logic               is_next_ccc_i,
  // Status
  output logic               target_idle_o,
  output logic               target_transmitting_o,
  output logic               xfer_in_progress_o,
  output logic               event_target_nack_o
);
  import i3c_bus_pkg::*;

  hdr_byte_u rx_byte;
  logic      hdr_load;
  logic      addr_match;
  logic      rsvd_match;
  logic      rnw;
  logic      rx_byte_done;
  logic      rx_tbit_done;
  logic      tx_load;
  logic      tx_tbit_done;
  logic      tx_end;
  byte_t     tx_byte;

  assign rx_byte.raw = bus_rx_data_i;

  i3c_addr_match i3c_addr_match_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .hdr_load_i        (hdr_load),
    .hdr_byte_i        (rx_byte),
    .clear_i           (target_idle_o),
    .start_i           (bus_start_det_i | bus_rstart_det_i),
    .sta_addr_i        (sta_addr_i),
    .sta_addr_valid_i  (sta_addr_valid_i),
    .dyn_addr_i        (dyn_addr_i),
    .dyn_addr_valid_i  (dyn_addr_valid_i),
    .addr_match_o      (addr_match),
    .rsvd_match_o      (rsvd_match),
    .rnw_o             (rnw),
    .last_addr_o       (last_addr_o),
    .last_addr_valid_o (last_addr_valid_o)
  );

  i3c_rx_path i3c_rx_path_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .byte_done_i       (rx_byte_done),
    .tbit_done_i       (rx_tbit_done),
    .rx_data_i         (bus_rx_data_i),
    .rx_fifo_wready_i  (rx_fifo_wready_i),
    .parity_err_o      (parity_err_o),
    .rx_overflow_err_o (rx_overflow_err_o),
    .rx_fifo_wvalid_o  (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o   (rx_fifo_wdata_o)
  );

  i3c_tx_path i3c_tx_path_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .load_i          (tx_load),
    .tbit_done_i     (tx_tbit_done),
    .tx_fifo_rdata_i (tx_fifo_rdata_i),
    .tx_last_byte_i  (tx_last_byte_i),
    .tx_byte_o       (tx_byte),
    .tx_end_o        (tx_end)
  );

  i3c_target_fsm i3c_target_fsm_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .target_enable_i       (target_enable_i),
    .bus_start_det_i       (bus_start_det_i),
    .bus_rstart_det_i      (bus_rstart_det_i),
    .bus_stop_det_i        (bus_stop_det_i),
    .bus_rx_done_i         (bus_rx_done_i),
    .bus_rx_data_i         (rx_byte),
    .bus_tx_done_i         (bus_tx_done_i),
    .addr_match_i          (addr_match),
    .rsvd_match_i          (rsvd_match),
    .rnw_i                 (rnw),
    .tx_desc_avail_i       (tx_desc_avail_i),
    .tx_fifo_rvalid_i      (tx_fifo_rvalid_i),
    .tx_last_byte_i        (tx_last_byte_i),
    .tx_end_i              (tx_end),
    .tx_byte_i             (tx_byte),
    .is_ccc_done_i         (is_ccc_done_i),
    .is_next_ccc_i         (is_next_ccc_i),
    .bus_rx_req_byte_o     (bus_rx_req_byte_o),
    .bus_rx_req_bit_o      (bus_rx_req_bit_o),
    .bus_tx_req_byte_o     (bus_tx_req_byte_o),
    .bus_tx_req_bit_o      (bus_tx_req_bit_o),
    .bus_tx_req_value_o    (bus_tx_req_value_o),
    .hdr_load_o            (hdr_load),
    .rx_byte_done_o        (rx_byte_done),
    .rx_tbit_done_o        (rx_tbit_done),
    .tx_load_o             (tx_load),
    .tx_tbit_done_o        (tx_tbit_done),
    .tx_fifo_rready_o      (tx_fifo_rready_o),
    .ccc_valid_o           (ccc_valid_o),
    .ccc_o                 (ccc_o),
    .target_idle_o         (target_idle_o),
    .target_transmitting_o (target_transmitting_o),
    .xfer_in_progress_o    (xfer_in_progress_o),
    .event_target_nack_o   (event_target_nack_o)
  );

endmodule : i3c_target_top

// File: i3c_tx_path.sv
/*
  Private read datapath fed by a show-ahead TX FIFO.
  The byte and its last marker are taken on the pop edge.
*/
`timescale 1ns/100ps

module i3c_tx_path (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               load_i,
  input  logic               tbit_done_i,
  input  i3c_bus_pkg::byte_t tx_fifo_rdata_i,
  input  logic               tx_last_byte_i,
  output i3c_bus_pkg::byte_t tx_byte_o,
  output logic               tx_end_o
);
  import i3c_bus_pkg::*;

  byte_t byte_q;
  logic  end_q;

  // Byte held on the bus for the whole data phase
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      byte_q <= tx_fifo_rdata_i;
    end
  end

  // End marker of the byte in flight, dropped after its T-bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      end_q <= 1'b0;
    end else if (load_i) begin
      end_q <= tx_last_byte_i;
    end else if (tbit_done_i) begin
      end_q <= 1'b0;
    end
  end

  assign tx_byte_o = byte_q;
  assign tx_end_o  = end_q;

endmodule : i3c_tx_path

// File: list.f
i3c_bus_pkg.sv
i3c_fsm_pkg.sv
i3c_addr_match.sv
i3c_rx_path.sv
i3c_tx_path.sv
i3c_target_fsm.sv
i3c_target_top.sv
tb_i3c_target.sv

// File: tb_i3c_target.sv
/*
  Directed testbench for the SDR target with a bit/byte PHY model.
  PHY latency is random, 1 to 4 cycles. RX and TX FIFOs are queue models.
*/
`timescale 1ns/100ps

module tb_i3c_target;

  localparam int ClkHalf = 20;
  localparam int ResetCycles = 4;
  localparam logic [31:0] Seed = 32'h7b22_234a;
  // Watchdog sized from the PHY symbols of all tests plus per-test overhead
  localparam int SymbolCount = 33;
  localparam int SymbolCycles = 8;
  localparam int TestCount = 6;
  localparam int TestCycles = 20;
  localparam int MaxCycles =
    2 * (SymbolCount * SymbolCycles + TestCount * TestCycles + ResetCycles);
  localparam logic [6:0] StaAddr = 7'h21;
  localparam logic [6:0] DynAddr = 7'h30;
  localparam logic [7:0] BroadcastByte = 8'hFC;
  localparam logic [7:0] CccCode = 8'h07;

  logic       clk_i = 1'b0;
  logic       rst_ni = 1'b0;
  logic       target_enable_i = 1'b0;
  logic       bus_start_det_i = 1'b0;
  logic       bus_rstart_det_i = 1'b0;
  logic       bus_stop_det_i = 1'b0;
  logic       bus_rx_done_i = 1'b0;
  logic [7:0] bus_rx_data_i = 8'h00;
  logic       bus_tx_done_i = 1'b0;
  logic       bus_rx_req_byte_o;
  logic       bus_rx_req_bit_o;
  logic       bus_tx_req_byte_o;
  logic       bus_tx_req_bit_o;
  logic [7:0] bus_tx_req_value_o;
  logic [6:0] sta_addr_i = 7'h00;
  logic       sta_addr_valid_i = 1'b0;
  logic [6:0] dyn_addr_i = 7'h00;
  logic       dyn_addr_valid_i = 1'b0;
  logic [7:0] last_addr_o;
  logic       last_addr_valid_o;
  logic       rx_fifo_wvalid_o;
  logic [7:0] rx_fifo_wdata_o;
  logic       rx_fifo_wready_i = 1'b1;
  logic       parity_err_o;
  logic       rx_overflow_err_o;
  logic       tx_desc_avail_i = 1'b0;
  logic       tx_fifo_rvalid_i = 1'b0;
  logic [7:0] tx_fifo_rdata_i = 8'h00;
  logic       tx_last_byte_i = 1'b0;
  logic       tx_fifo_rready_o;
  logic [7:0] ccc_o;
  logic       ccc_valid_o;
  logic       is_ccc_done_i = 1'b0;
  logic       is_next_ccc_i = 1'b0;
  logic       target_idle_o;
  logic       target_transmitting_o;
  logic       xfer_in_progress_o;
  logic       event_target_nack_o;

  // Bytes written to the RX FIFO, TX FIFO entries as {last, data}
  logic [7:0] rx_q[$];
  logic [8:0] tx_q[$];
  logic       tx_pop_seen = 1'b0;
  int         nack_count = 0;
  int         parity_count = 0;
  int         overflow_count = 0;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         cycle_count = 0;

  i3c_target_top i3c_target_top_i (.*);

  initial begin
    forever #ClkHalf clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    while (cycle_count < MaxCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", MaxCycles);
    $display("Test FAILED");
    $finish;
  end

  // Event counters and RX FIFO sink, sampled mid-cycle
  always @(negedge clk_i) begin
    if (event_target_nack_o) nack_count++;
    if (parity_err_o) parity_count++;
    if (rx_overflow_err_o) overflow_count++;
    if (rx_fifo_wvalid_o && rx_fifo_wready_i) rx_q.push_back(rx_fifo_wdata_o);
    tx_pop_seen = tx_fifo_rready_o;
  end

  // Show-ahead TX FIFO, popped on the edge after rready was seen
  always @(posedge clk_i) begin
    if (tx_pop_seen && tx_q.size() > 0) begin
      void'(tx_q.pop_front());
    end
    if (tx_q.size() > 0) begin
      tx_fifo_rvalid_i <= 1'b1;
      tx_fifo_rdata_i  <= tx_q[0][7:0];
      tx_last_byte_i   <= tx_q[0][8];
    end else begin
      tx_fifo_rvalid_i <= 1'b0;
      tx_fifo_rdata_i  <= 8'h00;
      tx_last_byte_i   <= 1'b0;
    end
  end

  // Odd parity over byte and T-bit
  function automatic logic tbit_for(input logic [7:0] data);
    return ($countones(data) % 2) == 0;
  endfunction

  // PHY delivers a received byte or bit once the target asks for it
  task automatic send_symbol(input logic is_bit, input logic [7:0] data);
    int delay;
    delay = 1 + int'($urandom % 32'd4);
    @(negedge clk_i);
    while (!(is_bit ? bus_rx_req_bit_o : bus_rx_req_byte_o)) begin
      @(negedge clk_i);
    end
    repeat (delay) @(posedge clk_i);
    bus_rx_done_i <= 1'b1;
    bus_rx_data_i <= data;
    @(posedge clk_i);
    bus_rx_done_i <= 1'b0;
  endtask

  // PHY takes a byte or bit driven by the target
  task automatic collect_symbol(input logic is_bit, output logic [7:0] value);
    int delay;
    delay = 1 + int'($urandom % 32'd4);
    @(negedge clk_i);
    while (!(is_bit ? bus_tx_req_bit_o : bus_tx_req_byte_o)) begin
      @(negedge clk_i);
    end
    value = bus_tx_req_value_o;
    repeat (delay) @(posedge clk_i);
    bus_tx_done_i <= 1'b1;
    @(posedge clk_i);
    bus_tx_done_i <= 1'b0;
  endtask

  task automatic raise_start(input logic repeated);
    @(posedge clk_i);
    if (repeated) begin
      bus_rstart_det_i <= 1'b1;
    end else begin
      bus_start_det_i <= 1'b1;
    end
    @(posedge clk_i);
    bus_start_det_i  <= 1'b0;
    bus_rstart_det_i <= 1'b0;
  endtask

  // Stop, Idle is expected one clock later
  task automatic end_transfer();
    @(posedge clk_i);
    bus_stop_det_i <= 1'b1;
    @(posedge clk_i);
    bus_stop_det_i <= 1'b0;
    @(negedge clk_i);
    if (!target_idle_o) begin
      $display("Stop did not return the target to Idle");
      errors++;
    end
  endtask

  // ACK bit is driven low
  task automatic take_ack();
    logic [7:0] v;
    collect_symbol(1'b1, v);
    if (v[0] !== 1'b0) begin
      $display("ERR bus_tx_req_value_o: got %02h, expected %02h", v, 8'h00);
      errors++;
    end
  endtask

  // Header rejected: no ACK request, one NACK event, target parked in Wait
  task automatic confirm_nack(input int nack_base);
    repeat (3) begin
      @(negedge clk_i);
      if (bus_tx_req_bit_o) begin
        $display("Target asked to drive a bit after a header it must not ACK");
        errors++;
      end
    end
    if (nack_count != nack_base + 1) begin
      $display("ERR event_target_nack_o pulses: got %0h, expected %0h",
               nack_count - nack_base, 1);
      errors++;
    end
    if (target_transmitting_o !== 1'b0 || target_idle_o !== 1'b0) begin
      $display("Target is not waiting for Sr or P after a NACK");
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int err_base);
    tests_run++;
    if (errors == err_base) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - err_base);
    end
  endtask

  task automatic addr_precedence();
    int err0;
    int nack0;
    err0 = errors;
    raise_start(1'b0);
    send_symbol(1'b0, {DynAddr, 1'b0});
    take_ack();
    @(negedge clk_i);
    if (last_addr_o !== {DynAddr, 1'b0}) begin
      $display("ERR last_addr_o: got %02h, expected %02h", last_addr_o, {DynAddr, 1'b0});
      errors++;
    end
    if (!last_addr_valid_o) begin
      $display("Last address not reported as valid after the header");
      errors++;
    end
    // Own address matched, so a transfer is under way
    if (xfer_in_progress_o !== 1'b1) begin
      $display("ERR xfer_in_progress_o: got %0h, expected %0h", xfer_in_progress_o, 1);
      errors++;
    end
    end_transfer();
    // Static address is shadowed by the valid dynamic one
    nack0 = nack_count;
    raise_start(1'b0);
    send_symbol(1'b0, {StaAddr, 1'b0});
    confirm_nack(nack0);
    if (last_addr_o !== {StaAddr, 1'b0}) begin
      $display("ERR last_addr_o: got %02h, expected %02h", last_addr_o, {StaAddr, 1'b0});
      errors++;
    end
    if (xfer_in_progress_o !== 1'b0) begin
      $display("ERR xfer_in_progress_o: got %0h, expected %0h", xfer_in_progress_o, 0);
      errors++;
    end
    end_transfer();
    close_test("address precedence", err0);
  endtask

  task automatic private_write();
    logic [7:0] wr [3];
    int         err0;
    int         base;
    int         par0;
    err0  = errors;
    wr[0] = 8'hA5;
    wr[1] = 8'h3C;
    wr[2] = 8'h01;
    base  = rx_q.size();
    par0  = parity_count;
    raise_start(1'b0);
    send_symbol(1'b0, {DynAddr, 1'b0});
    take_ack();
    for (int i = 0; i < 3; i++) begin
      send_symbol(1'b0, wr[i]);
      send_symbol(1'b1, {7'h00, tbit_for(wr[i])});
    end
    // Corrupted T-bit
    send_symbol(1'b0, 8'h77);
    send_symbol(1'b1, {7'h00, !tbit_for(8'h77)});
    repeat (3) @(negedge clk_i);
    if (parity_count != par0 + 1) begin
      $display("ERR parity_err_o pulses: got %0h, expected %0h", parity_count - par0, 1);
      errors++;
    end
    if (rx_q.size() != base + 3) begin
      $display("ERR rx_fifo_wvalid_o writes: got %0h, expected %0h", rx_q.size() - base, 3);
      errors++;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (rx_q[base + i] !== wr[i]) begin
          $display("ERR rx_fifo_wdata_o: got %02h, expected %02h", rx_q[base + i], wr[i]);
          errors++;
        end
      end
    end
    end_transfer();
    close_test("private write", err0);
  endtask

  task automatic write_overflow();
    int err0;
    int base;
    int ovf0;
    err0 = errors;
    base = rx_q.size();
    ovf0 = overflow_count;
    @(posedge clk_i);
    rx_fifo_wready_i <= 1'b0;
    raise_start(1'b0);
    send_symbol(1'b0, {DynAddr, 1'b0});
    take_ack();
    send_symbol(1'b0, 8'h5A);
    send_symbol(1'b1, {7'h00, tbit_for(8'h5A)});
    send_symbol(1'b0, 8'hC3);
    send_symbol(1'b1, {7'h00, tbit_for(8'hC3)});
    repeat (2) @(negedge clk_i);
    if (overflow_count != ovf0 + 1) begin
      $display("ERR rx_overflow_err_o pulses: got %0h, expected %0h",
               overflow_count - ovf0, 1);
      errors++;
    end
    @(posedge clk_i);
    rx_fifo_wready_i <= 1'b1;
    @(negedge clk_i);
    while (rx_fifo_wvalid_o) begin
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    if (rx_q.size() != base + 1) begin
      $display("ERR rx_fifo_wvalid_o writes: got %0h, expected %0h", rx_q.size() - base, 1);
      errors++;
    end else if (rx_q[base] !== 8'h5A) begin
      $display("ERR rx_fifo_wdata_o: got %02h, expected %02h", rx_q[base], 8'h5A);
      errors++;
    end
    end_transfer();
    close_test("overflow", err0);
  endtask

  task automatic private_read();
    logic [7:0] rd [3];
    logic [7:0] v;
    logic       exp_t;
    int         err0;
    err0  = errors;
    rd[0] = 8'h11;
    rd[1] = 8'h22;
    rd[2] = 8'h33;
    @(negedge clk_i);
    tx_q.push_back({1'b0, rd[0]});
    tx_q.push_back({1'b0, rd[1]});
    tx_q.push_back({1'b1, rd[2]});
    raise_start(1'b0);
    send_symbol(1'b0, {DynAddr, 1'b1});
    take_ack();
    for (int i = 0; i < 3; i++) begin
      collect_symbol(1'b0, v);
      if (v !== rd[i]) begin
        $display("ERR bus_tx_req_value_o: got %02h, expected %02h", v, rd[i]);
        errors++;
      end
      // T-bit low only after the last byte
      exp_t = (i < 2);
      collect_symbol(1'b1, v);
      if (v[0] !== exp_t) begin
        $display("ERR bus_tx_req_value_o: got %02h, expected %02h", v, {7'h00, exp_t});
        errors++;
      end
    end
    repeat (2) @(negedge clk_i);
    if (tx_q.size() != 0) begin
      $display("TX FIFO still holds %0d bytes after the read", tx_q.size());
      errors++;
    end
    if (target_transmitting_o !== 1'b0) begin
      $display("ERR target_transmitting_o: got %0h, expected %0h", target_transmitting_o, 0);
      errors++;
    end
    end_transfer();
    close_test("private read", err0);
  endtask

  task automatic broadcast_ccc();
    int err0;
    err0 = errors;
    raise_start(1'b0);
    send_symbol(1'b0, BroadcastByte);
    take_ack();
    send_symbol(1'b0, CccCode);
    @(negedge clk_i);
    if (ccc_o !== CccCode) begin
      $display("ERR ccc_o: got %02h, expected %02h", ccc_o, CccCode);
      errors++;
    end
    // Held until the engine is done
    repeat (3) begin
      @(negedge clk_i);
      if (ccc_valid_o !== 1'b1) begin
        $display("ERR ccc_valid_o: got %0h, expected %0h", ccc_valid_o, 1);
        errors++;
      end
    end
    @(posedge clk_i);
    is_ccc_done_i <= 1'b1;
    @(posedge clk_i);
    is_ccc_done_i <= 1'b0;
    @(negedge clk_i);
    while (!target_idle_o) begin
      @(negedge clk_i);
    end
    if (ccc_valid_o !== 1'b0) begin
      $display("ERR ccc_valid_o: got %0h, expected %0h", ccc_valid_o, 0);
      errors++;
    end
    close_test("broadcast CCC", err0);
  endtask

  task automatic broadcast_rstart_nack();
    int err0;
    int nack0;
    err0  = errors;
    nack0 = nack_count;
    raise_start(1'b0);
    send_symbol(1'b0, BroadcastByte);
    take_ack();
    // Direct read with no TX descriptor
    raise_start(1'b1);
    send_symbol(1'b0, {DynAddr, 1'b1});
    confirm_nack(nack0);
    end_transfer();
    close_test("broadcast Sr read NACK", err0);
  endtask

  initial begin
    void'($urandom(Seed));
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni           <= 1'b1;
    target_enable_i  <= 1'b1;
    sta_addr_i       <= StaAddr;
    sta_addr_valid_i <= 1'b1;
    dyn_addr_i       <= DynAddr;
    dyn_addr_valid_i <= 1'b1;
    @(posedge clk_i);
    addr_precedence();
    private_write();
    write_overflow();
    private_read();
    broadcast_ccc();
    broadcast_rstart_nack();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_i3c_target
